/* atr_ctrl.f */
+incdir+hdl
hdl/atr_pkg.sv
hdl/atr_regs.sv
hdl/atr_settle_timer.sv
hdl/atr_sequencer.sv
hdl/atr_top.sv
verification/atr_tb.sv

/* Makefile */
TOP = atr_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f atr_ctrl.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only -Wall --timing -f atr_ctrl.f --top-module atr_top

clean:
	rm -rf obj_dir

/* verification/atr_tb.sv */
/*
  Directed testbench for the ATR switch.
  Inputs change 2 ns after each rising edge, outputs are sampled at the same
  point before new inputs are driven.
  The pattern table has no reset, so every word is written before it is read.
  A watchdog ends the run after a fixed number of cycles.
*/
`timescale 1ns/1ps
`default_nettype none
`include "atr_defs.svh"

module atr_tb
   import atr_pkg::*;
();

   // Tests take roughly 250 cycles so the limit leaves a wide margin
   localparam int CYCLE_LIMIT = 3000;

   logic          clk_i = 1'b0;
   logic          rst_i;
   logic [5:0]    adr;
   logic [1:0]    sel;
   atr_bus_data_t wr_dat;
   logic          we;
   logic          stb;
   logic          cyc;
   atr_bus_data_t rd_dat;
   logic          ack;
   logic          run_rx;
   logic          run_tx;
   atr_line_t     ctrl_lines;
   logic          busy;

   // Expected table contents updated with every write
   atr_line_t     model [`ATR_TABLE_DEPTH];
   atr_mode_e     cur_mode;
   integer        seed;
   int            error_count;
   int            check_count;
   int            cycle_count = 0;

   atr_top atr_top_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .adr_i        (adr),
      .sel_i        (sel),
      .dat_i        (wr_dat),
      .we_i         (we),
      .stb_i        (stb),
      .cyc_i        (cyc),
      .dat_o        (rd_dat),
      .ack_o        (ack),
      .run_rx_i     (run_rx),
      .run_tx_i     (run_tx),
      .ctrl_lines_o (ctrl_lines),
      .busy_o       (busy)
   );

   // 20 ns clock
   always #10 clk_i = ~clk_i;

   // Watchdog against a hung handshake
   always @(posedge clk_i)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // Byte-lane rule with sel[1] on the upper byte and sel[0] on the lower byte of the half
   function automatic atr_line_t merge_lanes(atr_line_t old, logic upper,
                                             logic [1:0] lanes, atr_bus_data_t data);
      atr_line_t word;
      int        base;
      word = old;
      base = upper ? 16 : 0;
      if (lanes[0])
         word[base +: 8] = data[7:0];
      if (lanes[1])
         word[base + 8 +: 8] = data[15:8];
      return word;
   endfunction

   function automatic atr_bus_data_t half_of(atr_line_t word, logic upper);
      return upper ? word[31:16] : word[15:0];
   endfunction

   // Step past the next edge to the drive and sample point
   task automatic next_cycle;
      @(posedge clk_i);
      #2;
   endtask

   task automatic wait_ack;
      next_cycle;
      while (ack !== 1'b1)
         next_cycle;
   endtask

   task automatic end_access;
      we  = 1'b0;
      stb = 1'b0;
      cyc = 1'b0;
      next_cycle;
   endtask

   task automatic bus_write(atr_word_adr_t word, logic upper, logic [1:0] lanes,
                            atr_bus_data_t data);
      adr    = {word, upper, 1'b0};
      sel    = lanes;
      wr_dat = data;
      we     = 1'b1;
      stb    = 1'b1;
      cyc    = 1'b1;
      model[word] = merge_lanes(model[word], upper, lanes, data);
      wait_ack;
      end_access;
   endtask

   task automatic bus_read(atr_word_adr_t word, logic upper, output atr_bus_data_t data);
      adr = {word, upper, 1'b0};
      we  = 1'b0;
      stb = 1'b1;
      cyc = 1'b1;
      wait_ack;
      data = rd_dat;
      end_access;
   endtask

   task automatic set_run(atr_mode_e mode);
      run_rx = mode[1];
      run_tx = mode[0];
   endtask

   // Checks the pattern of the given mode on the lines and the busy level
   task automatic check_lines(atr_mode_e exp_mode, logic exp_busy);
      check_count++;
      if (ctrl_lines !== model[exp_mode])
      begin
         error_count++;
         $display("Mismatch ctrl_lines_o: got %h, expected %h", ctrl_lines, model[exp_mode]);
      end
      if (busy !== exp_busy)
      begin
         error_count++;
         $display("Mismatch busy_o: got %h, expected %h", busy, exp_busy);
      end
   endtask

   task automatic test_byte_lanes;
      atr_bus_data_t data;
      logic [1:0]    lanes;
      // Full fill first, then random lane masks on top
      for (int w = 0; w < `ATR_TABLE_DEPTH; w++)
         for (int h = 0; h < 2; h++)
         begin
            data = atr_bus_data_t'($random(seed));
            bus_write(atr_word_adr_t'(w), h[0], 2'b11, data);
         end
      for (int w = 0; w < `ATR_TABLE_DEPTH; w++)
         for (int h = 0; h < 2; h++)
         begin
            data  = atr_bus_data_t'($random(seed));
            lanes = 2'($random(seed));
            bus_write(atr_word_adr_t'(w), h[0], lanes, data);
         end
      for (int w = 0; w < `ATR_TABLE_DEPTH; w++)
         for (int h = 0; h < 2; h++)
         begin
            bus_read(atr_word_adr_t'(w), h[0], data);
            check_count++;
            if (data !== half_of(model[w], h[0]))
            begin
               error_count++;
               $display("Mismatch dat_o: got %h, expected %h", data, half_of(model[w], h[0]));
            end
         end
   endtask

   // Read held for 6 cycles gets an ack on every second one
   task automatic test_ack_pulse;
      logic exp_ack;
      adr = {4'd7, 1'b1, 1'b0};
      we  = 1'b0;
      stb = 1'b1;
      cyc = 1'b1;
      for (int i = 0; i < 6; i++)
      begin
         next_cycle;
         exp_ack = (i % 2 == 0);
         check_count++;
         if (ack !== exp_ack)
         begin
            error_count++;
            $display("Mismatch ack_o: got %h, expected %h", ack, exp_ack);
         end
         if (ack && rd_dat !== half_of(model[7], 1'b1))
         begin
            error_count++;
            $display("Mismatch dat_o: got %h, expected %h", rd_dat, half_of(model[7], 1'b1));
         end
      end
      end_access;
   endtask

   task automatic test_zero_delay;
      atr_mode_e mode;
      bus_write(atr_word_adr_t'(`ATR_DELAY_ADR), 1'b0, 2'b11, 16'h0000);
      for (int i = 1; i <= 4; i++)
      begin
         mode = atr_mode_e'(i % 4);
         set_run(mode);
         next_cycle;
         check_lines(mode, 1'b0);
         cur_mode = mode;
      end
   endtask

   // Old pattern and busy for D+1 samples, then the new pattern
   task automatic test_settle(atr_delay_t d, atr_mode_e target);
      bus_write(atr_word_adr_t'(`ATR_DELAY_ADR), 1'b0, 2'b11, d);
      set_run(target);
      repeat (d + 1)
      begin
         next_cycle;
         check_lines(cur_mode, 1'b1);
      end
      next_cycle;
      check_lines(target, 1'b0);
      cur_mode = target;
   endtask

   // Second change two cycles in restarts the full count
   task automatic test_retarget(atr_delay_t d, atr_mode_e first, atr_mode_e second);
      bus_write(atr_word_adr_t'(`ATR_DELAY_ADR), 1'b0, 2'b11, d);
      set_run(first);
      repeat (2)
      begin
         next_cycle;
         check_lines(cur_mode, 1'b1);
      end
      set_run(second);
      repeat (d + 1)
      begin
         next_cycle;
         check_lines(cur_mode, 1'b1);
      end
      next_cycle;
      check_lines(second, 1'b0);
      cur_mode = second;
   endtask

   // A return to the active mode cancels settling and the stale expiry leaves it alone
   task automatic test_cancel(atr_delay_t d, atr_mode_e other);
      bus_write(atr_word_adr_t'(`ATR_DELAY_ADR), 1'b0, 2'b11, d);
      set_run(other);
      repeat (2)
      begin
         next_cycle;
         check_lines(cur_mode, 1'b1);
      end
      set_run(cur_mode);
      next_cycle;
      check_lines(cur_mode, 1'b0);
      repeat (d + 2)
      begin
         next_cycle;
         check_lines(cur_mode, 1'b0);
      end
   endtask

   // Write to the active word shows right after the write edge
   task automatic test_live_update;
      atr_bus_data_t data;
      data   = atr_bus_data_t'($random(seed));
      adr    = {atr_word_adr_t'(cur_mode), 1'b1, 1'b0};
      sel    = 2'b11;
      wr_dat = data;
      we     = 1'b1;
      stb    = 1'b1;
      cyc    = 1'b1;
      check_lines(cur_mode, 1'b0);
      model[cur_mode] = merge_lanes(model[cur_mode], 1'b1, 2'b11, data);
      wait_ack;
      check_lines(cur_mode, 1'b0);
      end_access;
   endtask

   initial
   begin
      seed        = 90;
      error_count = 0;
      check_count = 0;
      rst_i       = 1'b1;
      adr         = '0;
      sel         = '0;
      wr_dat      = '0;
      we          = 1'b0;
      stb         = 1'b0;
      cyc         = 1'b0;
      run_rx      = 1'b0;
      run_tx      = 1'b0;
      cur_mode    = ATR_IDLE;
      repeat (3) @(posedge clk_i);
      #2;
      rst_i = 1'b0;
      check_count++;
      if (busy !== 1'b0)
      begin
         error_count++;
         $display("Mismatch busy_o: got %h, expected %h", busy, 1'b0);
      end
      if (ack !== 1'b0)
      begin
         error_count++;
         $display("Mismatch ack_o: got %h, expected %h", ack, 1'b0);
      end

      test_byte_lanes;
      test_ack_pulse;
      test_zero_delay;
      test_settle(16'd5, ATR_TX);
      test_settle(16'd1, ATR_FDX);
      test_retarget(16'd5, ATR_RX, ATR_IDLE);
      test_cancel(16'd5, ATR_TX);
      test_live_update;

      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/atr_top.sv */
/*
  ATR switch top level.
  Plain strobe bus, 16-bit data, ack is a one-cycle pulse per access.
  ctrl_lines_o follows the table word of the active mode combinationally.
  busy_o is high while a mode change waits out the settle delay.
  The pattern table is not reset, so software loads it before enabling runs.
*/
`timescale 1ns/1ps
`default_nettype none

module atr_top
   import atr_pkg::*;
(
   input  wire                clk_i,
   input  wire                rst_i,
   input  wire [5:0]          adr_i,
   input  wire [1:0]          sel_i,
   input  wire atr_bus_data_t dat_i,
   input  wire                we_i,
   input  wire                stb_i,
   input  wire                cyc_i,
   output atr_bus_data_t      dat_o,
   output logic               ack_o,
   input  wire                run_rx_i,
   input  wire                run_tx_i,
   output atr_line_t          ctrl_lines_o,
   output logic               busy_o
);

   atr_bus_req_t    bus_req;
   atr_seq_status_t seq_status;
   atr_delay_t      settle_delay;
   logic            timer_load;
   logic            timer_expired;

   // Bundle the bus inputs for the register bank
   assign bus_req = '{adr: adr_i, sel: sel_i, dat: dat_i,
                      we: we_i, stb: stb_i, cyc: cyc_i};

   atr_regs atr_regs_inst (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .bus_i          (bus_req),
      .dat_o          (dat_o),
      .ack_o          (ack_o),
      .mode_i         (seq_status.mode),
      .ctrl_lines_o   (ctrl_lines_o),
      .settle_delay_o (settle_delay)
   );

   // Timer reloads with the delay register on every new target
   atr_settle_timer atr_settle_timer_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .load_i       (timer_load),
      .load_value_i (settle_delay),
      .expired_o    (timer_expired)
   );

   atr_sequencer atr_sequencer_inst (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .run_rx_i       (run_rx_i),
      .run_tx_i       (run_tx_i),
      .settle_delay_i (settle_delay),
      .expired_i      (timer_expired),
      .timer_load_o   (timer_load),
      .status_o       (seq_status)
   );

   assign busy_o = seq_status.settling;

endmodule

`default_nettype wire

/* hdl/atr_sequencer.sv */
/*
  Mode sequencer.
  The run levels are sampled on every edge with no synchronizer, so they
  must come from the same clock domain.
  With a zero delay a new request takes over on the sampling edge. Otherwise
  the old mode holds while the settle timer runs, and the target commits on
  the edge after expired_i. A new target restarts the timer, and a return
  to the active mode cancels settling.
*/
`timescale 1ns/1ps
`default_nettype none

module atr_sequencer
   import atr_pkg::*;
(
   input  wire             clk_i,
   input  wire             rst_i,
   input  wire             run_rx_i,
   input  wire             run_tx_i,
   input  wire atr_delay_t settle_delay_i,
   input  wire             expired_i,
   output logic            timer_load_o,
   output atr_seq_status_t status_o
);

   atr_mode_e req_mode;
   atr_mode_e mode_q;
   atr_mode_e target_q;
   logic      settling_q;
   logic      delay_zero;
   logic      new_target;

   // Requested mode straight from the run levels
   assign req_mode = atr_mode_e'({run_rx_i, run_tx_i});

   assign delay_zero = (settle_delay_i == '0);

   // Request differs from both the active mode and any pending target
   assign new_target = (req_mode != mode_q) && (!settling_q || (req_mode != target_q));

   // Start or restart the timer toward a fresh target
   assign timer_load_o = new_target && !delay_zero;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         mode_q     <= ATR_IDLE;
         target_q   <= ATR_IDLE;
         settling_q <= 1'b0;
      end
      else if (req_mode == mode_q)
      begin
         // Back at the active mode, drop any pending change
         settling_q <= 1'b0;
         target_q   <= mode_q;
      end
      else if (delay_zero)
      begin
         // No settle time, switch on this edge
         mode_q     <= req_mode;
         target_q   <= req_mode;
         settling_q <= 1'b0;
      end
      else if (new_target)
      begin
         settling_q <= 1'b1;
         target_q   <= req_mode;
      end
      else if (expired_i)
      begin
         // Settle time done, commit the target
         mode_q     <= target_q;
         settling_q <= 1'b0;
      end
   end

   assign status_o = '{mode: mode_q, settling: settling_q};

   // A pending target is always a real change
   settle_target_a : assert property (@(posedge clk_i) disable iff (rst_i)
      settling_q |-> (target_q != mode_q));

   // A stale timer pulse after a cancel does not move the mode
   stale_expired_a : assert property (@(posedge clk_i) disable iff (rst_i)
      (expired_i && !settling_q && !delay_zero) |=> (mode_q == $past(mode_q)));

endmodule

`default_nettype wire

/* hdl/atr_settle_timer.sv */
/*
  Settle down-counter.
  A load starts or restarts the count. With a load value D the expired
  pulse comes D cycles after the load edge and lasts one cycle.
  A load of zero stops the counter without a pulse.
*/
`timescale 1ns/1ps
`default_nettype none

module atr_settle_timer
   import atr_pkg::*;
(
   input  wire             clk_i,
   input  wire             rst_i,
   input  wire             load_i,
   input  wire atr_delay_t load_value_i,
   output logic            expired_o
);

   atr_delay_t count_q;
   logic       running_q;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         count_q   <= '0;
         running_q <= 1'b0;
         expired_o <= 1'b0;
      end
      else if (load_i)
      begin
         // Restart, even mid count
         count_q   <= load_value_i;
         running_q <= (load_value_i != '0);
         expired_o <= 1'b0;
      end
      else if (running_q)
      begin
         count_q <= count_q - atr_delay_t'(1);
         // Last step, stop and flag
         if (count_q == atr_delay_t'(1))
         begin
            running_q <= 1'b0;
            expired_o <= 1'b1;
         end
         else
            expired_o <= 1'b0;
      end
      else
         expired_o <= 1'b0;
   end

   // The pulse only ever ends a run
   expired_after_run_a : assert property (@(posedge clk_i) disable iff (rst_i)
      expired_o |-> $past(running_q));

endmodule

`default_nettype wire

/* hdl/atr_regs.sv */
/*
  Bus slave and pattern table.
  Writes land on the edge where we, stb and cyc are all high, one byte lane
  per sel bit. Read data and ack follow one cycle later; read data is the
  half word as it was before a write on the same edge.
  The table has no reset, so words must be written before use.
  ctrl_lines_o is a combinational read of the word picked by mode_i.
*/
`timescale 1ns/1ps
`default_nettype none
`include "atr_defs.svh"

module atr_regs
   import atr_pkg::*;
(
   input  wire             clk_i,
   input  wire             rst_i,
   input  wire atr_bus_req_t bus_i,
   output atr_bus_data_t   dat_o,
   output logic            ack_o,
   input  wire atr_mode_e  mode_i,
   output atr_line_t       ctrl_lines_o,
   output atr_delay_t      settle_delay_o
);

   // Byte lanes in a table word and in a bus half
   localparam int LINE_LANES = `ATR_LINE_W / 8;
   localparam int BUS_LANES  = `ATR_BUS_W / 8;

   atr_line_t              table_q [`ATR_TABLE_DEPTH];
   atr_word_adr_t          word_adr;
   logic                   upper_half;
   logic                   wr_en;
   logic                   rd_req;
   logic [LINE_LANES-1:0]  lane_en;

   // Address bits 5:2 pick the word, bit 1 the half
   assign word_adr   = bus_i.adr[5:2];
   assign upper_half = bus_i.adr[1];

   assign wr_en  = bus_i.we & bus_i.stb & bus_i.cyc;

   // New access only when the previous ack is not still out
   assign rd_req = bus_i.stb & bus_i.cyc & ~ack_o;

   // Move the two bus lanes onto the addressed half
   assign lane_en = upper_half ? {bus_i.sel, {BUS_LANES{1'b0}}}
                               : {{BUS_LANES{1'b0}}, bus_i.sel};

   // Table write, lane b of the word takes bus byte b mod 2
   always_ff @(posedge clk_i)
   begin
      if (wr_en)
      begin
         for (int b = 0; b < LINE_LANES; b++)
         begin
            if (lane_en[b])
               table_q[word_adr][b*8 +: 8] <= bus_i.dat[(b % BUS_LANES)*8 +: 8];
         end
      end
   end

   // Ack pulse, never two cycles in a row
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         ack_o <= 1'b0;
      else
         ack_o <= rd_req;
   end

   // Read-back half, captured with the ack
   always_ff @(posedge clk_i)
   begin
      if (rd_req)
      begin
         if (upper_half)
            dat_o <= table_q[word_adr][`ATR_BUS_W +: `ATR_BUS_W];
         else
            dat_o <= table_q[word_adr][`ATR_BUS_W-1:0];
      end
   end

   // Control side, the active mode indexes words 0 to 3
   assign ctrl_lines_o = table_q[atr_word_adr_t'(mode_i)];

   // Delay word exports its lower half only
   assign settle_delay_o = table_q[`ATR_DELAY_ADR][`ATR_BUS_W-1:0];

   // A held request gets an ack on alternate cycles
   ack_pulse_a : assert property (@(posedge clk_i) disable iff (rst_i)
      ack_o |=> !ack_o);

endmodule

`default_nettype wire

/* hdl/atr_pkg.sv */
/*
  Shared types for the ATR switch.
  The mode encoding doubles as the table index of the active pattern,
  so the enum values must stay 0 to 3 in this order.
  The bus request struct carries one cycle of bus inputs, no response.
*/
`default_nettype none
`include "atr_defs.svh"

package atr_pkg;

   // One control-line pattern, a full table word
   typedef logic [`ATR_LINE_W-1:0] atr_line_t;

   // Bus data, one half of a table word
   typedef logic [`ATR_BUS_W-1:0] atr_bus_data_t;

   // Table word index
   typedef logic [$clog2(`ATR_TABLE_DEPTH)-1:0] atr_word_adr_t;

   // Settle count in clock cycles
   typedef logic [`ATR_BUS_W-1:0] atr_delay_t;

   // Mode from the run levels, {run_rx, run_tx}
   typedef enum logic [1:0] {
      ATR_IDLE = 2'd0,
      ATR_TX   = 2'd1,
      ATR_RX   = 2'd2,
      ATR_FDX  = 2'd3
   } atr_mode_e;

   // One bus request as seen on a clock edge
   typedef struct packed {
      logic [5:0]    adr;
      logic [1:0]    sel;
      atr_bus_data_t dat;
      logic          we;
      logic          stb;
      logic          cyc;
   } atr_bus_req_t;

   // Sequencer status, active mode plus settle flag
   typedef struct packed {
      atr_mode_e mode;
      logic      settling;
   } atr_seq_status_t;

endpackage

`default_nettype wire

/* hdl/atr_defs.svh */
/*
  Sizing constants for the ATR switch.
  The table holds 32-bit patterns written over a 16-bit bus, so one word
  takes two bus halves. Words 0 to 3 are the mode patterns, word 4 holds
  the settle delay in its lower half. The remaining words are plain storage.
  The bus address is 6 bits wide, which limits the table to 16 words.
*/
`ifndef ATR_DEFS_SVH
`define ATR_DEFS_SVH

// Number of 32-bit words in the pattern table
`define ATR_TABLE_DEPTH 16

// Width of the daughterboard control lines
`define ATR_LINE_W 32

// Width of bus data, one half of a table word
`define ATR_BUS_W 16

// Word holding the settle delay (lower half, in clock cycles)
`define ATR_DELAY_ADR 4

`endif
